/* all.f */
+incdir+rtl
rtl/cheat_pkg.sv
rtl/prog_packer.sv
rtl/insn_ram.sv
rtl/cheat_seq.sv
rtl/bank_arbiter.sv
rtl/cheat_top.sv
testbench/cheat_tb.sv

/* rtl/bank_arbiter.sv */
// Shares SDRAM bank 0 between the game and the cheat sequencer
// Game wins on an idle bank and the owner keeps it until ba0_rdy
module bank_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  cheat_pkg::mem_req_t game,
    output logic                game_rdy,
    input  cheat_pkg::mem_req_t cheat,
    output logic                cheat_rdy,
    output cheat_pkg::mem_req_t ba0,
    input  logic                ba0_rdy
);
    import cheat_pkg::*;

    typedef enum logic [1:0] {
        own_none,
        own_game,
        own_cheat
    } owner_t;

    owner_t owner;
    logic   game_req;
    logic   cheat_req;

    assign game_req  = game.rd | game.wr;
    assign cheat_req = cheat.rd | cheat.wr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= own_none;
        end else begin
            case (owner)
                own_none: begin
                    if (game_req) begin
                        owner <= own_game;
                    end else if (cheat_req) begin
                        owner <= own_cheat;
                    end
                end
                default: begin
                    if (ba0_rdy) begin
                        owner <= own_none;
                    end
                end
            endcase
        end
    end

    // Idle bank drives no request
    always_comb begin
        ba0 = '0;
        case (owner)
            own_game:  ba0 = game;
            own_cheat: ba0 = cheat;
            default:   ba0 = '0;
        endcase
    end

    assign game_rdy  = (owner == own_game) && ba0_rdy;
    assign cheat_rdy = (owner == own_cheat) && ba0_rdy;

    a_one_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        !(game_rdy && cheat_rdy));

    // Requesters must hold their access while the bank works on it
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((ba0.rd || ba0.wr) && !ba0_rdy) |=> $stable(ba0));

endmodule

/* rtl/cheat_consts.svh */
// Widths and opcodes shared by the cheat unit RTL and its testbench
// Include in any file that sizes buses or decodes instructions
`ifndef CHEAT_CONSTS_SVH
`define CHEAT_CONSTS_SVH

// SDRAM word address width
`define CHEAT_AW 22

// Instruction word and instruction RAM address widths
`define CHEAT_IW  18
`define CHEAT_IAW 12

// Sequencer opcodes
`define CHEAT_OP_END     2'd0
`define CHEAT_OP_ADDR_HI 2'd1
`define CHEAT_OP_ADDR_LO 2'd2
`define CHEAT_OP_WRITE   2'd3

`endif

/* rtl/cheat_pkg.sv */
// Bus and instruction types for the cheat unit
// Modules import this package and use its structs on their ports
`include "cheat_consts.svh"

package cheat_pkg;

    // One access to SDRAM bank 0
    typedef struct packed {
        logic [`CHEAT_AW-1:0] addr;
        logic [15:0]          din;
        // Set bit leaves that byte untouched
        logic [1:0]           din_m;
        logic                 rd;
        logic                 wr;
    } mem_req_t;

    // Opcode sits in the top two bits
    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] arg;
    } cheat_insn_t;

    // Instruction RAM write port
    typedef struct packed {
        logic [`CHEAT_IAW-1:0] addr;
        cheat_insn_t           insn;
        logic                  we;
    } prog_wr_t;

endpackage

/* rtl/cheat_seq.sv */
// Cheat sequencer woken at each start of vertical blanking
// Runs the instruction RAM program and issues masked SDRAM writes
`include "cheat_consts.svh"

module cheat_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lvbl,
    input  logic                   enable,
    output logic [`CHEAT_IAW-1:0]  rd_addr,
    input  cheat_pkg::cheat_insn_t insn,
    output cheat_pkg::mem_req_t    req,
    input  logic                   rdy
);
    import cheat_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_wait_wr
    } state_t;

    state_t                state;
    logic                  lvbl_l;
    logic                  vb_fall;
    logic [`CHEAT_IAW-1:0] pc;
    logic [`CHEAT_AW-1:0]  cur_addr;
    logic [1:0]            mask;
    logic [15:0]           din_q;
    logic                  wr_q;

    // RAM latches pc at the end of the fetch cycle
    assign rd_addr = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            lvbl_l   <= 1'b0;
            vb_fall  <= 1'b0;
            pc       <= '0;
            cur_addr <= '0;
            mask     <= '0;
            wr_q     <= 1'b0;
        end else begin
            lvbl_l  <= lvbl;
            vb_fall <= lvbl_l && !lvbl;
            case (state)
                st_idle: begin
                    // Edges seen mid-run are dropped here
                    if (vb_fall && enable) begin
                        pc       <= '0;
                        cur_addr <= '0;
                        mask     <= '0;
                        state    <= st_fetch;
                    end
                end
                st_fetch: begin
                    state <= st_exec;
                end
                st_exec: begin
                    pc    <= pc + 1'b1;
                    state <= st_fetch;
                    case (insn.op)
                        `CHEAT_OP_END: begin
                            state <= st_idle;
                        end
                        `CHEAT_OP_ADDR_HI: begin
                            cur_addr[`CHEAT_AW-1:16] <= insn.arg[5:0];
                            mask                     <= insn.arg[9:8];
                        end
                        `CHEAT_OP_ADDR_LO: begin
                            cur_addr[15:0] <= insn.arg;
                        end
                        default: begin
                            wr_q  <= 1'b1;
                            state <= st_wait_wr;
                        end
                    endcase
                end
                default: begin
                    // Hold the write until the arbiter passes rdy back
                    if (rdy) begin
                        wr_q     <= 1'b0;
                        cur_addr <= cur_addr + 1'b1;
                        state    <= st_fetch;
                    end
                end
            endcase
        end
    end

    // Write data is payload only
    always_ff @(posedge clk) begin
        if (state == st_exec && insn.op == `CHEAT_OP_WRITE) begin
            din_q <= insn.arg;
        end
    end

    assign req.addr  = cur_addr;
    assign req.din   = din_q;
    assign req.din_m = mask;
    assign req.rd    = 1'b0;
    assign req.wr    = wr_q;

    a_wr_held: assert property (@(posedge clk) disable iff (!rst_n)
        (req.wr && !rdy) |=> req.wr);

endmodule

/* rtl/cheat_top.sv */
// Cheat unit top level placed between the game and SDRAM bank 0
// Host loads the program through prog_* and lvbl falls start each run
`include "cheat_consts.svh"

module cheat_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lvbl,
    input  logic                enable,
    input  cheat_pkg::mem_req_t game,
    output logic                game_rdy,
    output cheat_pkg::mem_req_t ba0,
    input  logic                ba0_rdy,
    input  logic                prog_en,
    input  logic                prog_wr,
    input  logic [7:0]          prog_data
);
    import cheat_pkg::*;

    prog_wr_t              ram_wr;
    logic [`CHEAT_IAW-1:0] rd_addr;
    cheat_insn_t           insn;
    mem_req_t              cheat_req;
    logic                  cheat_rdy;

    prog_packer u_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data),
        .wr        (ram_wr)
    );

    insn_ram u_ram (
        .clk     (clk),
        .wr      (ram_wr),
        .rd_addr (rd_addr),
        .q       (insn)
    );

    cheat_seq u_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .lvbl    (lvbl),
        .enable  (enable),
        .rd_addr (rd_addr),
        .insn    (insn),
        .req     (cheat_req),
        .rdy     (cheat_rdy)
    );

    bank_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .game      (game),
        .game_rdy  (game_rdy),
        .cheat     (cheat_req),
        .cheat_rdy (cheat_rdy),
        .ba0       (ba0),
        .ba0_rdy   (ba0_rdy)
    );

endmodule

/* rtl/insn_ram.sv */
// Instruction RAM between the program packer and the sequencer
// Registered read, one cycle latency, old data on a same-address collision
`include "cheat_consts.svh"

module insn_ram (
    input  logic                   clk,
    input  cheat_pkg::prog_wr_t    wr,
    input  logic [`CHEAT_IAW-1:0]  rd_addr,
    output cheat_pkg::cheat_insn_t q
);
    import cheat_pkg::*;

    localparam int DEPTH = 1 << `CHEAT_IAW;

    cheat_insn_t mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.insn;
        end
    end

    // Read sees the array before this edge's write
    always_ff @(posedge clk) begin
        q <= mem[rd_addr];
    end

endmodule

/* rtl/prog_packer.sv */
// Packs the host byte stream, LSB first, into 18-bit instruction words
// Each finished word is written to the next instruction RAM address
`include "cheat_consts.svh"

module prog_packer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               prog_en,
    input  logic               prog_wr,
    input  logic [7:0]         prog_data,
    output cheat_pkg::prog_wr_t wr
);
    import cheat_pkg::*;

    logic                  last_en;
    logic                  start;
    logic                  take;
    logic                  word_done;
    // Up to 17 leftover bits plus one new byte
    logic [24:0]           acc;
    logic [24:0]           acc_app;
    logic [4:0]            fill;
    logic [4:0]            fill_app;
    // Extra top bit flags a full RAM
    logic [`CHEAT_IAW:0]   word_cnt;
    logic                  we_q;
    logic [`CHEAT_IAW-1:0] addr_q;
    cheat_insn_t           insn_q;

    assign start     = prog_en && !last_en;
    assign take      = prog_en && prog_wr && !start;
    assign acc_app   = acc | (25'(prog_data) << fill);
    assign fill_app  = fill + 5'd8;
    assign word_done = take && (fill_app >= 5'd18);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_en  <= 1'b0;
            fill     <= '0;
            word_cnt <= '0;
            we_q     <= 1'b0;
        end else begin
            last_en <= prog_en;
            we_q    <= word_done;
            if (start) begin
                fill     <= '0;
                word_cnt <= '0;
            end else if (word_done) begin
                fill     <= fill_app - 5'd18;
                word_cnt <= word_cnt + 1'b1;
            end else if (take) begin
                fill <= fill_app;
            end
        end
    end

    // Accumulator and output word
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (take) begin
            acc <= word_done ? (acc_app >> 18) : acc_app;
        end
        if (word_done) begin
            insn_q <= cheat_insn_t'(acc_app[`CHEAT_IW-1:0]);
            addr_q <= word_cnt[`CHEAT_IAW-1:0];
        end
    end

    assign wr.addr = addr_q;
    assign wr.insn = insn_q;
    assign wr.we   = we_q;

    // A program longer than the RAM would overwrite its own start
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (prog_en && word_done) |-> !word_cnt[`CHEAT_IAW]);

endmodule

/* testbench/cheat_tb.sv */
// Testbench for the cheat unit with an SDRAM bank model and a case table
// Each case loads a program, drops lvbl and checks the write log and memory
`include "cheat_consts.svh"

module cheat_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cheat_pkg::*;

    typedef struct {
        logic [`CHEAT_AW-1:0] addr;
        logic [15:0]          data;
        logic [1:0]           mask;
        int                   count;
    } entry_t;

    // Entries of a case sit at ents[first +: n_ent]
    typedef struct {
        string name;
        int    first;
        int    n_ent;
        bit    en;
        bit    traffic;
    } case_t;

    localparam logic [31:0] SEED    = 32'hd04d_5b9c;
    localparam int          TIMEOUT = 2000;

    logic        clk;
    logic        rst_n;
    logic        lvbl;
    logic        enable;
    mem_req_t    game;
    logic        game_rdy;
    mem_req_t    ba0;
    logic        ba0_rdy;
    logic        prog_en;
    logic        prog_wr;
    logic [7:0]  prog_data;

    case_t       cases [$];
    entry_t      ents [$];
    cheat_insn_t prog_words [$];
    mem_req_t    cheat_log [$];
    logic [15:0] mem [logic [`CHEAT_AW-1:0]];
    logic [15:0] game_exp [logic [`CHEAT_AW-1:0]];
    logic [31:0] bank_rng;
    logic [31:0] game_rng;

    cheat_top u_cheat_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .lvbl      (lvbl),
        .enable    (enable),
        .game      (game),
        .game_rdy  (game_rdy),
        .ba0       (ba0),
        .ba0_rdy   (ba0_rdy),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_data (prog_data)
    );

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Unwritten words read back a pattern of the whole address
    function automatic logic [15:0] fill_word(logic [`CHEAT_AW-1:0] a);
        return a[15:0] ^ {4'h0, a[21:16], 6'h2a} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] mem_read(logic [`CHEAT_AW-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    // A set mask bit keeps the old byte
    function automatic logic [15:0] merge(logic [15:0] old, logic [15:0] d, logic [1:0] m);
        return {m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]};
    endfunction

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_req(string name, mem_req_t exp, mem_req_t act);
        if (act !== exp) begin
            report_fail($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
        if (act !== exp) begin
            report_fail($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic add_case(string name, bit en, bit traffic, int n_ent);
        case_t c;
        c.name    = name;
        c.first   = ents.size();
        c.n_ent   = n_ent;
        c.en      = en;
        c.traffic = traffic;
        cases.push_back(c);
    endtask

    task automatic add_entry(logic [21:0] a, logic [15:0] d, logic [1:0] m, int cnt);
        entry_t e;
        e.addr  = a;
        e.data  = d;
        e.mask  = m;
        e.count = cnt;
        ents.push_back(e);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Bank model answers each access 2 to 5 cycles after it appears
    initial begin : bank_model
        mem_req_t req_s;
        logic     rdy_s;
        logic     busy;
        int       cnt;
        ba0_rdy = 1'b0;
        busy    = 1'b0;
        cnt     = 0;
        forever begin
            @(negedge clk);
            req_s = ba0;
            rdy_s = ba0_rdy;
            @(posedge clk);
            #1;
            if (rdy_s) begin
                ba0_rdy = 1'b0;
                busy    = 1'b0;
                if (req_s.wr) begin
                    mem[req_s.addr] = merge(mem_read(req_s.addr), req_s.din, req_s.din_m);
                    // Game traffic stays in the top quarter of the bank
                    if (req_s.addr[21:20] != 2'b11) begin
                        cheat_log.push_back(req_s);
                    end
                end
            end else if (busy) begin
                cnt = cnt - 1;
                if (cnt == 0) begin
                    ba0_rdy = 1'b1;
                end
            end else if (req_s.rd || req_s.wr) begin
                bank_rng = xorshift(bank_rng);
                cnt      = 1 + int'(bank_rng[1:0]);
                busy     = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && game_rdy && !(game.rd || game.wr)) begin
            report_fail("game_rdy pulsed while the game had no request pending");
        end
    end

    task automatic game_traffic(string name, int n);
        mem_req_t r;
        int       t;
        for (int i = 0; i < n; i++) begin
            game_rng = xorshift(game_rng);
            r        = '0;
            r.addr   = {2'b11, 12'h000, game_rng[7:0]};
            r.din    = game_rng[31:16];
            r.wr     = game_rng[8];
            r.rd     = !game_rng[8];
            @(posedge clk);
            #1;
            game = r;
            t    = 0;
            @(negedge clk);
            while (!game_rdy) begin
                t++;
                if (t > TIMEOUT) begin
                    report_fail($sformatf("%s: game request %0d never got game_rdy", name, i));
                end
                @(negedge clk);
            end
            if (r.wr) begin
                game_exp[r.addr] = r.din;
            end
            @(posedge clk);
            #1;
            game = '0;
        end
    endtask

    task automatic wait_writes(string name, int n);
        int t;
        t = 0;
        while (cheat_log.size() < n) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                report_fail($sformatf("%s: timed out waiting for cheat writes", name));
            end
        end
    endtask

    // ADDR_HI, ADDR_LO and the writes for every entry, then END
    task automatic build_program(case_t c);
        cheat_insn_t w;
        entry_t      e;
        prog_words.delete();
        for (int k = c.first; k < c.first + c.n_ent; k++) begin
            e     = ents[k];
            w.op  = `CHEAT_OP_ADDR_HI;
            w.arg = {6'h00, e.mask, 2'b00, e.addr[21:16]};
            prog_words.push_back(w);
            w.op  = `CHEAT_OP_ADDR_LO;
            w.arg = e.addr[15:0];
            prog_words.push_back(w);
            for (int i = 0; i < e.count; i++) begin
                w.op  = `CHEAT_OP_WRITE;
                w.arg = e.data + 16'(i);
                prog_words.push_back(w);
            end
        end
        w.op  = `CHEAT_OP_END;
        w.arg = '0;
        prog_words.push_back(w);
    endtask

    // Bit stream LSB first, last byte padded with zeros
    task automatic load_program();
        int         nbits;
        int         idx;
        logic [7:0] b;
        nbits = prog_words.size() * `CHEAT_IW;
        @(posedge clk);
        #1;
        prog_en = 1'b1;
        for (int k = 0; k < (nbits + 7) / 8; k++) begin
            for (int j = 0; j < 8; j++) begin
                idx  = 8 * k + j;
                b[j] = (idx < nbits) ? prog_words[idx / `CHEAT_IW][idx % `CHEAT_IW] : 1'b0;
            end
            @(posedge clk);
            #1;
            prog_wr   = 1'b1;
            prog_data = b;
        end
        @(posedge clk);
        #1;
        prog_wr = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        prog_en = 1'b0;
    endtask

    task automatic run_case(case_t c);
        mem_req_t exp;
        entry_t   e;
        int       n_exp;
        int       k;
        mem.delete();
        game_exp.delete();
        cheat_log.delete();
        build_program(c);
        load_program();
        n_exp = 0;
        for (int i = c.first; i < c.first + c.n_ent; i++) begin
            n_exp += c.en ? ents[i].count : 0;
        end
        @(posedge clk);
        #1;
        enable = c.en;
        lvbl   = 1'b0;
        fork
            begin
                if (c.traffic) begin
                    game_traffic(c.name, 12);
                end
            end
            begin
                repeat (4) @(posedge clk);
                #1;
                lvbl = 1'b1;
                wait_writes(c.name, n_exp);
            end
        join
        // Run is over once END has been fetched and the bank stays idle
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            if (ba0.rd || ba0.wr) begin
                report_fail($sformatf("%s: bank access seen after the run ended", c.name));
            end
        end
        if (cheat_log.size() != n_exp) begin
            report_fail($sformatf("error %s: expected %0d writes, actual %0d",
                                  c.name, n_exp, cheat_log.size()));
        end
        k = 0;
        for (int i = c.first; i < c.first + c.n_ent && c.en; i++) begin
            e = ents[i];
            for (int j = 0; j < e.count; j++) begin
                exp       = '0;
                exp.addr  = e.addr + 22'(j);
                exp.din   = e.data + 16'(j);
                exp.din_m = e.mask;
                exp.wr    = 1'b1;
                check_req(c.name, exp, cheat_log[k]);
                check_word(c.name, merge(fill_word(exp.addr), exp.din, exp.din_m),
                           mem_read(exp.addr));
                k++;
            end
        end
        foreach (game_exp[a]) begin
            check_word(c.name, game_exp[a], mem_read(a));
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        lvbl      = 1'b1;
        enable    = 1'b0;
        game      = '0;
        prog_en   = 1'b0;
        prog_wr   = 1'b0;
        prog_data = '0;
        bank_rng  = SEED;
        game_rng  = xorshift(SEED);
        add_case("single", 1'b1, 1'b0, 1);
        add_entry(22'h01_2345, 16'hbeef, 2'b00, 1);
        add_case("pair_masked", 1'b1, 1'b0, 1);
        add_entry(22'h2a_0ff0, 16'h1234, 2'b01, 2);
        add_case("two_runs", 1'b1, 1'b0, 2);
        add_entry(22'h00_fffe, 16'ha5a5, 2'b10, 3);
        add_entry(22'h15_4000, 16'h0f0f, 2'b00, 2);
        add_case("disabled", 1'b0, 1'b0, 1);
        add_entry(22'h01_0000, 16'hdead, 2'b00, 1);
        add_case("game_mix", 1'b1, 1'b1, 2);
        add_entry(22'h20_0100, 16'h5500, 2'b00, 4);
        add_entry(22'h0a_1230, 16'h00aa, 2'b01, 1);
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_req("reset", '0, ba0);
        if (game_rdy !== 1'b0) begin
            report_fail($sformatf("error reset: expected game_rdy 0, actual %b", game_rdy));
        end
        foreach (cases[i]) begin
            run_case(cases[i]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule
